/* cgra_io.f */
logic/cgra_conf_pkg.sv
logic/cgra_pe_pkg.sv
logic/cgra_memory.sv
logic/cgra_conf_reader.sv
logic/cgra_initial_conf.sv
logic/cgra_program_counter.sv
logic/cgra_alu.sv
logic/cgra_pe_io.sv
logic/cgra_io_top.sv
testbench/tb_cgra_io.sv

/* Makefile */
SIM_BIN = obj_dir/Vtb_cgra_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f cgra_io.f --top-module tb_cgra_io
	verilator --lint-only logic/cgra_conf_pkg.sv logic/cgra_pe_pkg.sv logic/cgra_memory.sv \
		logic/cgra_conf_reader.sv logic/cgra_initial_conf.sv logic/cgra_program_counter.sv \
		logic/cgra_alu.sv logic/cgra_pe_io.sv logic/cgra_io_top.sv --top-module cgra_io_top

sim:
	verilator --binary --timing -f cgra_io.f --top-module tb_cgra_io
	./$(SIM_BIN) | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

/* testbench/tb_cgra_io.sv */
`timescale 1ns/1ps

module tb_cgra_io
  import cgra_conf_pkg::*;
  import cgra_pe_pkg::*;
();

  localparam int DATA_WIDTH = 16;
  localparam int NCASE = 6;
  localparam int NSTEP = 64;
  localparam int PLEN = 8;
  localparam int RST_CYCLES = 8;
  localparam int CONF_CYCLES = 19;

  typedef logic [DATA_WIDTH-1:0] word_t;

  logic                       clk = 1'b0;
  logic                       rst = 1'b1;
  logic                       en = 1'b0;
  conf_word_t                 conf_bus_in = '0;
  init_conf_t                 init_conf_bus_in = '0;
  logic [1:0][DATA_WIDTH-1:0] fifo_in_data = '0;
  logic [1:0]                 fifo_in_re;
  logic [1:0][DATA_WIDTH-1:0] fifo_out_data;
  logic [1:0]                 fifo_out_we;

  // Stimulus table with one entry per test case.
  string      case_name [NCASE];
  pe_inst_t   prog [NCASE][2][PLEN];
  word_t      const_base [NCASE][2];
  logic [7:0] pc_max_t [NCASE][2];
  logic [7:0] pc_loop_t [NCASE][2];
  logic [7:0] ignore_t [NCASE][2];
  logic [15:0] en_pat [NCASE];
  int         steps_t [NCASE];

  // Reference model state for the current case.
  word_t words [2][NSTEP];
  word_t cur_outa [2][NSTEP];
  word_t rf_hist [2][NSTEP][8];
  word_t exp_data [2][NSTEP];
  bit    reads_at [2][NSTEP];
  int    exp_n [2];
  int    need [2];

  logic [31:0] lfsr_state = 32'ha364bd10;
  int          cycle_cnt = 0;
  int          limit = 0;
  int          cur_case = 0;
  bit          running = 1'b0;
  int          en_edges;
  int          rd_cnt [2];
  int          obs [2];
  int          rd_ptr [2];
  logic [1:0]  re_seen = '0;
  int          err_value = 0;
  int          err_other = 0;

  cgra_io_top #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_dut (
    .clk(clk),
    .rst(rst),
    .en(en),
    .conf_bus_in(conf_bus_in),
    .init_conf_bus_in(init_conf_bus_in),
    .fifo_in_data(fifo_in_data),
    .fifo_in_re(fifo_in_re),
    .fifo_out_data(fifo_out_data),
    .fifo_out_we(fifo_out_we)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output word_t w);
    w = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[DATA_WIDTH-2:0], lfsr_state[0]};
    end
  endtask

  function automatic pe_inst_t mk_inst(input alu_op_e op, input pe_src_e sa, input pe_src_e sb,
                                       input pe_dst_e d, input int ra, input int wa);
    return '{op: op, src_a: sa, src_b: sb, dst: d, rf_raddr: 3'(ra), rf_waddr: 3'(wa)};
  endfunction

  // Straight-line program with op codes counting up from first_op.
  task automatic fill_seq(input int c, input int p, input int first_op, input pe_dst_e d);
    for (int i = 0; i < PLEN; i++) begin
      prog[c][p][i] = mk_inst(alu_op_e'(4'(first_op + i)), src_fifo, src_rf, d, i, i);
    end
  endtask

  task automatic set_case(input int c, input string name, input word_t b0, input word_t b1,
                          input int max0, input int loop0, input int max1, input int loop1,
                          input int ign0, input int ign1, input logic [15:0] pat,
                          input int steps);
    case_name[c] = name;
    const_base[c][0] = b0;
    const_base[c][1] = b1;
    pc_max_t[c][0] = 8'(max0);
    pc_loop_t[c][0] = 8'(loop0);
    pc_max_t[c][1] = 8'(max1);
    pc_loop_t[c][1] = 8'(loop1);
    ignore_t[c][0] = 8'(ign0);
    ignore_t[c][1] = 8'(ign1);
    en_pat[c] = pat;
    steps_t[c] = steps;
  endtask

  function automatic word_t const_of(input int c, input int p, input int r);
    return const_base[c][p] + word_t'(16'h0123 * r);
  endfunction

  function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
    word_t prod;
    prod = a * b;
    case (op)
      alu_add:    return a + b;
      alu_sub:    return a - b;
      alu_mul:    return prod;
      alu_and:    return a & b;
      alu_or:     return a | b;
      alu_xor:    return a ^ b;
      alu_shl:    return a << b[3:0];
      alu_shr:    return a >> b[3:0];
      alu_min:    return (a < b) ? a : b;
      alu_max:    return (a < b) ? b : a;
      alu_pass_a: return a;
      alu_pass_b: return b;
      default:    return '0;
    endcase
  endfunction

  function automatic word_t select_src(input pe_src_e s, input word_t ia, input word_t ib,
                                       input word_t rv, input word_t fv);
    case (s)
      src_ina: return ia;
      src_inb: return ib;
      src_rf:  return rv;
      default: return fv;
    endcase
  endfunction

  // Replays both programs step by step in fetch order.
  task automatic run_model(input int c);
    pe_inst_t   inst;
    word_t      a;
    word_t      b;
    word_t      r;
    word_t      rfv;
    word_t      fv;
    word_t      iav;
    word_t      ibv;
    logic [7:0] pc [2];
    int         rd [2];
    int         fcnt [2];
    for (int p = 0; p < 2; p++) begin
      pc[p] = '0;
      rd[p] = 0;
      fcnt[p] = 0;
      exp_n[p] = 0;
      need[p] = 0;
    end
    for (int t = 0; t < steps_t[c] + 16; t++) begin
      for (int p = 0; p < 2; p++) begin
        inst = prog[c][p][pc[p]];
        rfv = (t >= 5) ? rf_hist[p][t-5][inst.rf_raddr] : const_of(c, p, int'(inst.rf_raddr));
        iav = (p == 1 && t >= 4) ? cur_outa[0][t-4] : '0;
        ibv = (p == 0 && t >= 4) ? cur_outa[1][t-4] : '0;
        reads_at[p][t] = (inst.src_a == src_fifo || inst.src_b == src_fifo);
        fv = '0;
        if (reads_at[p][t]) begin
          fv = words[p][rd[p]];
          rd[p]++;
        end
        a = select_src(inst.src_a, iav, ibv, rfv, fv);
        b = select_src(inst.src_b, iav, ibv, rfv, fv);
        r = alu_ref(inst.op, a, b);
        for (int k = 0; k < 8; k++) begin
          rf_hist[p][t][k] = (t > 0) ? rf_hist[p][t-1][k] : const_of(c, p, k);
        end
        cur_outa[p][t] = (t > 0) ? cur_outa[p][t-1] : '0;
        case (inst.dst)
          dst_outa: cur_outa[p][t] = r;
          dst_rf:   rf_hist[p][t][inst.rf_waddr] = r;
          dst_fifo: begin
            if (fcnt[p] >= int'(ignore_t[c][p])) begin
              exp_data[p][exp_n[p]] = r;
              exp_n[p]++;
            end
            fcnt[p]++;
          end
          default: ;
        endcase
        if (t == steps_t[c] - 1) begin
          need[p] = exp_n[p];
        end
        pc[p] = (pc[p] == pc_max_t[c][p]) ? pc_loop_t[c][p] : pc[p] + 8'd1;
      end
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      err_value++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      err_value++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Words for PE 0 and PE 1 alternate so that a misrouted word shifts a program.
  task automatic configure(input int c);
    int p;
    int k;
    for (int i = 0; i < 2 * PLEN; i++) begin
      p = i % 2;
      k = i / 2;
      conf_bus_in = '{valid: 1'b1, pe_id: 4'(p), inst: 16'(prog[c][p][k])};
      init_conf_bus_in = '{valid: 1'b1, pe_id: 4'(p), pc_max: pc_max_t[c][p],
                           pc_loop: pc_loop_t[c][p], ignore_until: ignore_t[c][p],
                           const_val: 16'(const_of(c, p, k))};
      @(negedge clk);
    end
    conf_bus_in = '0;
    init_conf_bus_in = '0;
    repeat (CONF_CYCLES - 2 * PLEN) @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    re_seen <= fifo_in_re;
    if (running) begin
      if (!en && (|fifo_in_re || |fifo_out_we)) begin
        err_other++;
        $display("Strobe pulsed while en was low in %s", case_name[cur_case]);
      end
      if (en) begin
        en_edges++;
      end
      for (int p = 0; p < 2; p++) begin
        if (fifo_in_re[p]) begin
          rd_cnt[p]++;
        end
        if (fifo_out_we[p]) begin
          if (obs[p] < exp_n[p]) begin
            check_word($sformatf("%s pe%0d result %0d", case_name[cur_case], p, obs[p]),
                       exp_data[p][obs[p]], fifo_out_data[p]);
          end else begin
            err_other++;
            $display("Unexpected extra result from PE %0d in %s", p, case_name[cur_case]);
          end
          obs[p]++;
        end
      end
    end
  end

  // FIFO provider presents the next word in the cycle after a read.
  always @(negedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (re_seen[p] && rd_ptr[p] < NSTEP) begin
        fifo_in_data[p] <= words[p][rd_ptr[p]];
        rd_ptr[p]++;
      end
    end
  end

  initial begin
    wait (limit > 0 && cycle_cnt >= limit);
    $display("Timeout after %0d cycles in %s", cycle_cnt, case_name[cur_case]);
    $display("Errors found");
    $finish;
  end

  initial begin
    int cyc;
    int exp_rd;
    int lim;
    fill_seq(0, 0, 0, dst_fifo);
    fill_seq(0, 1, 4, dst_outb);
    set_case(0, "conf_routing", 16'h0105, 16'h0a31, 7, 0, 7, 0, 0, 0, 16'hffff, 24);
    fill_seq(1, 0, 0, dst_fifo);
    fill_seq(1, 1, 8, dst_fifo);
    set_case(1, "alu_ops", 16'h0307, 16'h7c12, 7, 0, 7, 0, 0, 0, 16'hffff, 24);
    fill_seq(2, 1, 11, dst_outb);
    for (int i = 0; i < PLEN; i++) begin
      prog[2][0][i] = mk_inst(alu_add, src_fifo, src_rf, dst_outa, 1, 0);
    end
    prog[2][1][4] = mk_inst(alu_mul, src_ina, src_rf, dst_fifo, 2, 0);
    prog[2][1][5] = mk_inst(alu_mul, src_ina, src_rf, dst_rf, 2, 5);
    prog[2][1][7] = mk_inst(alu_pass_a, src_rf, src_rf, dst_fifo, 5, 0);
    set_case(2, "neighbour", 16'h0011, 16'h0003, 0, 0, 7, 4, 0, 0, 16'hffff, 32);
    fill_seq(3, 0, 0, dst_fifo);
    fill_seq(3, 1, 5, dst_fifo);
    set_case(3, "loop", 16'h2101, 16'h0046, 5, 3, 7, 2, 0, 0, 16'hffff, 30);
    fill_seq(4, 0, 2, dst_fifo);
    fill_seq(4, 1, 6, dst_fifo);
    set_case(4, "startup_filter", 16'h0f0f, 16'h1234, 7, 1, 7, 0, 3, 5, 16'hffff, 24);
    fill_seq(5, 0, 0, dst_fifo);
    fill_seq(5, 1, 3, dst_fifo);
    set_case(5, "freeze", 16'h5a5a, 16'h0102, 7, 1, 7, 3, 0, 0, 16'b0110111000111011, 32);

    lim = 0;
    for (int c = 0; c < NCASE; c++) begin
      lim += 10 * (RST_CYCLES + CONF_CYCLES + 2 * steps_t[c] + 8);
    end
    limit = lim;

    for (int c = 0; c < NCASE; c++) begin
      for (int p = 0; p < 2; p++) begin
        for (int k = 0; k < NSTEP; k++) begin
          random_word(words[p][k]);
        end
      end
      run_model(c);
      @(negedge clk);
      cur_case = c;
      en = 1'b0;
      rst = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      rd_ptr = '{0, 0};
      configure(c);
      en_edges = 0;
      rd_cnt = '{0, 0};
      obs = '{0, 0};
      running = 1'b1;
      cyc = 0;
      while (obs[0] < need[0] || obs[1] < need[1]) begin
        en = en_pat[c][cyc % 16];
        cyc++;
        @(negedge clk);
      end
      en = 1'b0;
      @(negedge clk);
      running = 1'b0;
      for (int p = 0; p < 2; p++) begin
        exp_rd = 0;
        for (int i = 0; i <= en_edges - 3 && i < NSTEP; i++) begin
          exp_rd += int'(reads_at[p][i]);
        end
        check_count($sformatf("%s pe%0d fifo_in_re count", case_name[c], p), exp_rd, rd_cnt[p]);
      end
    end

    $display("Value errors: %0d, other errors: %0d", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* logic/cgra_io_top.sv */
`timescale 1ns/1ps

module cgra_io_top
  import cgra_conf_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       en,
  input  conf_word_t                 conf_bus_in,
  input  init_conf_t                 init_conf_bus_in,
  input  logic [1:0][DATA_WIDTH-1:0] fifo_in_data,
  output logic [1:0]                 fifo_in_re,
  output logic [1:0][DATA_WIDTH-1:0] fifo_out_data,
  output logic [1:0]                 fifo_out_we
);

  conf_word_t            conf_mid;
  init_conf_t            init_mid;
  logic [DATA_WIDTH-1:0] pe0_outa;
  logic [DATA_WIDTH-1:0] pe1_outa;

  // PE 0 sits at the head of both configuration chains.
  cgra_pe_io #(
    .DATA_WIDTH(DATA_WIDTH),
    .PE_ID(0)
  ) pe0 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .conf_bus_in(conf_bus_in),
    .conf_bus_out(conf_mid),
    .init_conf_bus_in(init_conf_bus_in),
    .init_conf_bus_out(init_mid),
    .ina('0),
    .inb(pe1_outa),
    .outa(pe0_outa),
    .outb(),
    .fifo_in_data(fifo_in_data[0]),
    .fifo_in_re(fifo_in_re[0]),
    .fifo_out_data(fifo_out_data[0]),
    .fifo_out_we(fifo_out_we[0])
  );

  // PE 1 ends the column and its chain outputs go nowhere.
  cgra_pe_io #(
    .DATA_WIDTH(DATA_WIDTH),
    .PE_ID(1)
  ) pe1 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .conf_bus_in(conf_mid),
    .conf_bus_out(),
    .init_conf_bus_in(init_mid),
    .init_conf_bus_out(),
    .ina(pe0_outa),
    .inb('0),
    .outa(pe1_outa),
    .outb(),
    .fifo_in_data(fifo_in_data[1]),
    .fifo_in_re(fifo_in_re[1]),
    .fifo_out_data(fifo_out_data[1]),
    .fifo_out_we(fifo_out_we[1])
  );

endmodule

/* logic/cgra_pe_io.sv */
`timescale 1ns/1ps

module cgra_pe_io
  import cgra_conf_pkg::*;
  import cgra_pe_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int PE_ID = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  conf_word_t            conf_bus_in,
  output conf_word_t            conf_bus_out,
  input  init_conf_t            init_conf_bus_in,
  output init_conf_t            init_conf_bus_out,
  input  logic [DATA_WIDTH-1:0] ina,
  input  logic [DATA_WIDTH-1:0] inb,
  output logic [DATA_WIDTH-1:0] outa,
  output logic [DATA_WIDTH-1:0] outb,
  input  logic [DATA_WIDTH-1:0] fifo_in_data,
  output logic                  fifo_in_re,
  output logic [DATA_WIDTH-1:0] fifo_out_data,
  output logic                  fifo_out_we
);

  typedef logic [DATA_WIDTH-1:0] word_t;

  // Control carried down the pipe with each instruction.
  typedef struct packed {
    logic                 vld;
    alu_op_e              op;
    pe_src_e              src_a;
    pe_src_e              src_b;
    pe_dst_e              dst;
    logic [RF_ADDR_W-1:0] waddr;
  } ctl_t;

  logic                   inst_we;
  logic [INST_ADDR_W-1:0] inst_waddr;
  pe_inst_t               inst_wdata;
  pe_inst_t               inst_word;
  logic [INST_ADDR_W-1:0] pc;
  loop_conf_t             loop_conf;
  logic                   const_we;
  logic [RF_ADDR_W-1:0]   const_waddr;
  word_t                  const_val;

  logic                   inst_vld;
  logic                   s2_vld;
  pe_inst_t               s2_inst;
  ctl_t                   s3_ctl;
  ctl_t                   s4_ctl;
  ctl_t                   s5_ctl;
  word_t                  ina_q;
  word_t                  inb_q;
  word_t                  opnd_a;
  word_t                  opnd_b;
  word_t                  alu_result;

  logic                   rf_re;
  word_t                  rf_rdata;
  logic                   rf_we_q;
  logic [RF_ADDR_W-1:0]   rf_waddr_q;
  word_t                  rf_wdata;
  logic                   fifo_hit;
  logic                   fifo_we_q;
  logic [7:0]             ignore_cnt;

  function automatic word_t pick_operand(
    input pe_src_e sel,
    input word_t   from_ina,
    input word_t   from_inb,
    input word_t   from_rf,
    input word_t   from_fifo
  );
    case (sel)
      src_ina: return from_ina;
      src_inb: return from_inb;
      src_rf:  return from_rf;
      default: return from_fifo;
    endcase
  endfunction

  // Stage 2 issues the FIFO and register file reads, data arrives in stage 3.
  assign fifo_in_re = en && s2_vld &&
                      (s2_inst.src_a == src_fifo || s2_inst.src_b == src_fifo);
  assign rf_re = en && s2_vld && (s2_inst.src_a == src_rf || s2_inst.src_b == src_rf);
  assign fifo_hit = s5_ctl.vld && (s5_ctl.dst == dst_fifo);

  // Write strobe lines up with fifo_out_data.
  assign fifo_out_we = fifo_we_q && en;

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_vld <= 1'b0;
      s2_vld <= 1'b0;
      s2_inst <= '0;
      s3_ctl <= '0;
      s4_ctl <= '0;
      s5_ctl <= '0;
      rf_we_q <= 1'b0;
      fifo_we_q <= 1'b0;
      ignore_cnt <= '0;
    end else if (en) begin
      inst_vld <= 1'b1;
      s2_vld <= inst_vld;
      s2_inst <= inst_word;
      s3_ctl <= '{
        vld:   s2_vld,
        op:    s2_inst.op,
        src_a: s2_inst.src_a,
        src_b: s2_inst.src_b,
        dst:   s2_inst.dst,
        waddr: s2_inst.rf_waddr
      };
      s4_ctl <= s3_ctl;
      s5_ctl <= s4_ctl;
      rf_we_q <= s5_ctl.vld && (s5_ctl.dst == dst_rf);
      // Drop the first ignore_until FIFO results.
      fifo_we_q <= fifo_hit && (ignore_cnt == loop_conf.ignore_until);
      if (fifo_hit && ignore_cnt != loop_conf.ignore_until) begin
        ignore_cnt <= ignore_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      ina_q <= ina;
      inb_q <= inb;
      opnd_a <= pick_operand(s3_ctl.src_a, ina_q, inb_q, rf_rdata, fifo_in_data);
      opnd_b <= pick_operand(s3_ctl.src_b, ina_q, inb_q, rf_rdata, fifo_in_data);
      rf_waddr_q <= s5_ctl.waddr;
      if (s5_ctl.vld) begin
        case (s5_ctl.dst)
          dst_outa: outa <= alu_result;
          dst_outb: outb <= alu_result;
          dst_rf:   rf_wdata <= alu_result;
          default:  fifo_out_data <= alu_result;
        endcase
      end
    end
  end

  cgra_conf_reader #(
    .PE_ID(PE_ID)
  ) conf_reader (
    .clk(clk),
    .rst(rst),
    .conf_bus_in(conf_bus_in),
    .conf_bus_out(conf_bus_out),
    .inst_we(inst_we),
    .inst_waddr(inst_waddr),
    .inst_data(inst_wdata)
  );

  cgra_initial_conf #(
    .PE_ID(PE_ID),
    .DATA_WIDTH(DATA_WIDTH)
  ) init_conf (
    .clk(clk),
    .rst(rst),
    .init_conf_bus_in(init_conf_bus_in),
    .init_conf_bus_out(init_conf_bus_out),
    .const_we(const_we),
    .const_waddr(const_waddr),
    .const_val(const_val),
    .loop_conf(loop_conf)
  );

  cgra_program_counter program_counter (
    .clk(clk),
    .rst(rst),
    .en(en),
    .pc_max(loop_conf.pc_max),
    .pc_loop(loop_conf.pc_loop),
    .pc(pc)
  );

  cgra_memory #(
    .DATA_T(pe_inst_t),
    .ADDR_W(INST_ADDR_W)
  ) inst_mem (
    .clk(clk),
    .we(inst_we),
    .waddr(inst_waddr),
    .din(inst_wdata),
    .re(en),
    .raddr(pc),
    .dout(inst_word)
  );

  // Constant loads win over ALU write-back.
  cgra_memory #(
    .DATA_T(word_t),
    .ADDR_W(RF_ADDR_W)
  ) rf (
    .clk(clk),
    .we(const_we || (rf_we_q && en)),
    .waddr(const_we ? const_waddr : rf_waddr_q),
    .din(const_we ? const_val : rf_wdata),
    .re(rf_re),
    .raddr(s2_inst.rf_raddr),
    .dout(rf_rdata)
  );

  cgra_alu #(
    .DATA_WIDTH(DATA_WIDTH)
  ) alu (
    .clk(clk),
    .en(en),
    .op(s4_ctl.op),
    .ina(opnd_a),
    .inb(opnd_b),
    .result(alu_result)
  );

endmodule

/* logic/cgra_alu.sv */
`timescale 1ns/1ps

module cgra_alu
  import cgra_pe_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  en,
  input  alu_op_e               op,
  input  logic [DATA_WIDTH-1:0] ina,
  input  logic [DATA_WIDTH-1:0] inb,
  output logic [DATA_WIDTH-1:0] result
);

  localparam int SHAMT_W = $clog2(DATA_WIDTH);

  logic [SHAMT_W-1:0]    shamt;
  logic [DATA_WIDTH-1:0] result_d;

  // Shift amount is b modulo the width.
  assign shamt = SHAMT_W'(inb % DATA_WIDTH);

  always_comb begin
    result_d = '0;
    case (op)
      alu_add:    result_d = ina + inb;
      alu_sub:    result_d = ina - inb;
      alu_mul:    result_d = ina * inb;
      alu_and:    result_d = ina & inb;
      alu_or:     result_d = ina | inb;
      alu_xor:    result_d = ina ^ inb;
      alu_shl:    result_d = ina << shamt;
      alu_shr:    result_d = ina >> shamt;
      alu_min:    result_d = (ina < inb) ? ina : inb;
      alu_max:    result_d = (ina > inb) ? ina : inb;
      alu_pass_a: result_d = ina;
      alu_pass_b: result_d = inb;
      default:    result_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      result <= result_d;
    end
  end

endmodule

/* logic/cgra_program_counter.sv */
`timescale 1ns/1ps

module cgra_program_counter
  import cgra_pe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  logic [INST_ADDR_W-1:0] pc_max,
  input  logic [INST_ADDR_W-1:0] pc_loop,
  output logic [INST_ADDR_W-1:0] pc
);

  // The preamble below pc_loop runs once, the body repeats.
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (en) begin
      if (pc == pc_max) begin
        pc <= pc_loop;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

/* logic/cgra_initial_conf.sv */
`timescale 1ns/1ps

module cgra_initial_conf
  import cgra_conf_pkg::*;
  import cgra_pe_pkg::*;
#(
  parameter int PE_ID = 0,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  init_conf_t            init_conf_bus_in,
  output init_conf_t            init_conf_bus_out,
  output logic                  const_we,
  output logic [RF_ADDR_W-1:0]  const_waddr,
  output logic [DATA_WIDTH-1:0] const_val,
  output loop_conf_t            loop_conf
);

  logic [RF_ADDR_W-1:0] const_ptr;

  assign const_we = init_conf_bus_in.valid &&
                    (init_conf_bus_in.pe_id == PE_ID_W'(PE_ID));
  assign const_waddr = const_ptr;

  // Zero-extended or truncated to the data width.
  assign const_val = DATA_WIDTH'(init_conf_bus_in.const_val);

  always_ff @(posedge clk) begin
    if (rst) begin
      init_conf_bus_out <= '0;
      const_ptr <= '0;
      loop_conf <= '0;
    end else begin
      init_conf_bus_out <= init_conf_bus_in;
      if (const_we) begin
        // Pointer wraps after eight constants.
        const_ptr <= const_ptr + 1'b1;
        loop_conf <= '{
          pc_max:       init_conf_bus_in.pc_max,
          pc_loop:      init_conf_bus_in.pc_loop,
          ignore_until: init_conf_bus_in.ignore_until
        };
      end
    end
  end

endmodule

/* logic/cgra_conf_reader.sv */
`timescale 1ns/1ps

module cgra_conf_reader
  import cgra_conf_pkg::*;
  import cgra_pe_pkg::*;
#(
  parameter int PE_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  conf_word_t             conf_bus_in,
  output conf_word_t             conf_bus_out,
  output logic                   inst_we,
  output logic [INST_ADDR_W-1:0] inst_waddr,
  output pe_inst_t               inst_data
);

  logic [INST_ADDR_W-1:0] wr_ptr;

  assign inst_we = conf_bus_in.valid && (conf_bus_in.pe_id == PE_ID_W'(PE_ID));
  assign inst_waddr = wr_ptr;
  assign inst_data = pe_inst_t'(conf_bus_in.inst);

  // Words for other elements pass on one cycle later.
  always_ff @(posedge clk) begin
    if (rst) begin
      conf_bus_out <= '0;
      wr_ptr <= '0;
    end else begin
      conf_bus_out <= conf_bus_in;
      if (inst_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

endmodule

/* logic/cgra_memory.sv */
`timescale 1ns/1ps

module cgra_memory #(
  parameter type DATA_T = logic [15:0],
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  DATA_T             din,
  input  logic              re,
  input  logic [ADDR_W-1:0] raddr,
  output DATA_T             dout
);

  DATA_T mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
  end

  // Read data holds while re is low.
  always_ff @(posedge clk) begin
    if (re) begin
      dout <= mem[raddr];
    end
  end

endmodule

/* logic/cgra_pe_pkg.sv */
package cgra_pe_pkg;

  localparam int INST_ADDR_W = 8;
  localparam int RF_ADDR_W = 3;

  // Codes 12 to 15 give zero.
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_mul    = 4'd2,
    alu_and    = 4'd3,
    alu_or     = 4'd4,
    alu_xor    = 4'd5,
    alu_shl    = 4'd6,
    alu_shr    = 4'd7,
    alu_min    = 4'd8,
    alu_max    = 4'd9,
    alu_pass_a = 4'd10,
    alu_pass_b = 4'd11
  } alu_op_e;

  typedef enum logic [1:0] {src_ina, src_inb, src_rf, src_fifo} pe_src_e;

  typedef enum logic [1:0] {dst_outa, dst_outb, dst_rf, dst_fifo} pe_dst_e;

  // Op sits in the top four bits of the word.
  typedef struct packed {
    alu_op_e                op;
    pe_src_e                src_a;
    pe_src_e                src_b;
    pe_dst_e                dst;
    logic [RF_ADDR_W-1:0]   rf_raddr;
    logic [RF_ADDR_W-1:0]   rf_waddr;
  } pe_inst_t;

endpackage

/* logic/cgra_conf_pkg.sv */
package cgra_conf_pkg;

  localparam int PE_ID_W = 4;

  // One instruction word travelling down the configuration chain.
  typedef struct packed {
    logic               valid;
    logic [PE_ID_W-1:0] pe_id;
    logic [15:0]        inst;
  } conf_word_t;

  // Loop and start-up settings kept by each element.
  typedef struct packed {
    logic [7:0] pc_max;
    logic [7:0] pc_loop;
    logic [7:0] ignore_until;
  } loop_conf_t;

  // Initial configuration word carrying one register file constant.
  typedef struct packed {
    logic               valid;
    logic [PE_ID_W-1:0] pe_id;
    logic [7:0]         pc_max;
    logic [7:0]         pc_loop;
    logic [7:0]         ignore_until;
    logic [15:0]        const_val;
  } init_conf_t;

endpackage
